// File: bench/memory_control_assertions.sv
`timescale 1ns/1ps

// protocol properties, bound into memory_control
module memory_control_assertions import coherence_pkg::*; (
  input logic        CLK,
  input logic        nRST,
  input cache_resp_t resp [2],
  input ram_req_t    ram_req
);

  int fails; // failed assertions so far

  // one transaction in flight so at most one peer under snoop
  a_one_snoop: assert property (@(posedge CLK) disable iff (!nRST)
    !(resp[0].ccwait && resp[1].ccwait))
    else begin
      fails++;
      $error("ccwait high for both cores at once");
    end

  for (genvar c = 0; c < 2; c++) begin : g_core
    // completing wait bit is a single-cycle low
    a_iwait_pulse: assert property (@(posedge CLK) disable iff (!nRST)
      !resp[c].iwait |=> resp[c].iwait)
      else begin
        fails++;
        $error("iwait low for more than one cycle on core %0d", c);
      end

    a_dwait_pulse: assert property (@(posedge CLK) disable iff (!nRST)
      !resp[c].dwait |=> resp[c].dwait)
      else begin
        fails++;
        $error("dwait low for more than one cycle on core %0d", c);
      end

    a_inv_pulse: assert property (@(posedge CLK) disable iff (!nRST)
      resp[c].ccinv |=> !resp[c].ccinv) // one pulse only
      else begin
        fails++;
        $error("ccinv high for more than one cycle on core %0d", c);
      end
  end

  // ram port is either read or write
  a_ram_rw: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ren && ram_req.wen))
    else begin
      fails++;
      $error("ram ren and wen high together");
    end

endmodule

// File: bench/memory_control_checker.sv
`timescale 1ns/1ps

// reference model of the ram that predicts every completion
module memory_control_checker import coherence_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  req [2],
  input  cache_resp_t resp [2],
  output int          errors,
  output int          completions
);

  logic [DATA_W-1:0] model [RAM_WORDS]; // expected ram contents
  logic              snp_seen;          // peer reply taken for the current read
  logic              snp_dirty;
  logic [DATA_W-1:0] snp_data;
  int                inv_pulses;        // ccinv pulses since last data completion
  int                last_core;         // -1 until the first completion
  logic              other_pending;     // peer was waiting at last completion

  task automatic mismatch(input string test, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    errors++;
    $display("Error %s expected %h actual %h", test, exp, act);
  endtask

  task automatic fault(input string what);
    errors++;
    $display("at %0t: %s", $time, what);
  endtask

  // snoop reply from core p to the requesting other core
  task automatic watch_snoop(input int p);
    int r;
    r = 1 - p;
    if (resp[p].ccinv)
      inv_pulses++;
    if (resp[p].ccwait && req[p].cctrans) begin
      snp_seen  = 1'b1;
      snp_dirty = req[p].ccwrite;
      snp_data  = req[p].dstore;
      if (resp[p].ccsnoopaddr !== req[r].daddr)
        mismatch("snoop_addr", req[r].daddr, resp[p].ccsnoopaddr);
      if (resp[p].ccinv !== req[r].cctrans) // invalidate only on ownership
        mismatch("ccinv", req[r].cctrans, resp[p].ccinv);
    end else if (resp[p].ccinv) begin
      fault("ccinv pulsed outside a snoop reply");
    end
  endtask

  task automatic check_completion(input int c);
    logic [RAM_AW-1:0] idx;
    logic [DATA_W-1:0] exp;
    string             test;
    if (!resp[c].iwait) begin
      idx = req[c].iaddr[RAM_AW-1:0];
      if (!req[c].iren)
        fault("iwait dropped with no fetch pending");
      else if (resp[c].iload !== model[idx])
        mismatch("ifetch", model[idx], resp[c].iload);
    end
    if (!resp[c].dwait) begin
      idx = req[c].daddr[RAM_AW-1:0];
      if (req[c].dren) begin
        if (!snp_seen)
          fault("data read completed without a snoop reply");
        if (snp_seen && snp_dirty) begin
          exp  = snp_data; // peer supplies
          test = req[c].cctrans ? "read_own_dirty" : "read_shared_dirty";
          if (!req[c].cctrans)
            model[idx] = snp_data; // shared read flushes the word to ram
        end else begin
          exp  = model[idx];
          test = req[c].cctrans ? "read_own_clean" : "read_shared_clean";
        end
        if (resp[c].dload !== exp)
          mismatch(test, exp, resp[c].dload);
        if (inv_pulses != (req[c].cctrans ? 1 : 0))
          mismatch("ccinv_count", req[c].cctrans ? 1 : 0, inv_pulses);
      end else if (req[c].dwen) begin
        model[idx] = req[c].dstore; // eviction lands in ram
      end else begin
        fault("dwait dropped with no data request pending");
      end
      snp_seen   = 1'b0;
      inv_pulses = 0;
    end
    if (!resp[c].iwait || !resp[c].dwait) begin
      completions++;
      // waiting peer must be served before this core again
      if (last_core == c && other_pending)
        mismatch("fairness", 1 - c, c);
      last_core     = c;
      other_pending = req[1-c].iren | req[1-c].dren | req[1-c].dwen;
    end
  endtask

  always @(posedge CLK) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        model[i] = '0; // ram clears on reset
      end
      snp_seen   = 1'b0;
      snp_dirty  = 1'b0;
      inv_pulses = 0;
      last_core  = -1;
      other_pending = 1'b0;
      for (int c = 0; c < 2; c++) begin
        if (resp[c].iwait !== 1'b1 || resp[c].dwait !== 1'b1)
          fault("wait bit not high during reset");
        if (resp[c].ccwait !== 1'b0 || resp[c].ccinv !== 1'b0)
          fault("ccwait or ccinv active during reset");
      end
    end else begin
      watch_snoop(0);
      watch_snoop(1);
      check_completion(0);
      check_completion(1);
    end
  end

endmodule

// File: bench/memory_control_tb.sv
`timescale 1ns/1ps

// two random cache agents with snoop responders around the memory subsystem
module memory_control_tb import coherence_pkg::*; ();

  localparam int TXNS    = 200; // per core
  localparam int TIMEOUT = 200; // cycles per wait

  logic        CLK;
  logic        nRST;
  cache_req_t  req [2];
  cache_resp_t resp [2];

  // request side of each agent
  logic              r_iren  [2];
  logic              r_dren  [2];
  logic              r_dwen  [2];
  logic              r_own   [2]; // ownership wanted on dren
  logic [ADDR_W-1:0] r_iaddr [2];
  logic [ADDR_W-1:0] r_daddr [2];
  logic [DATA_W-1:0] r_store [2];

  // snoop reply side of each agent
  logic              snp_busy  [2]; // being snooped
  logic              snp_valid [2];
  logic              snp_dirty [2];
  logic [1:0]        snp_cnt   [2]; // cycles left before the reply
  logic [DATA_W-1:0] snp_data  [2];

  int   chk_errors;
  int   chk_done;
  int   asrt_errors; // bound assertion failures
  int   timeouts;
  logic abort;

  coherent_memory_top dut0 (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .resp (resp)
  );

  memory_control_checker watch0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .resp        (resp),
    .errors      (chk_errors),
    .completions (chk_done)
  );

  bind memory_control memory_control_assertions asrt0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .resp    (resp),
    .ram_req (ram_req)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  // snoop reply overrides cctrans/ccwrite/dstore while snooped
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      req[c].iren    = r_iren[c];
      req[c].dren    = r_dren[c];
      req[c].dwen    = r_dwen[c];
      req[c].iaddr   = r_iaddr[c];
      req[c].daddr   = r_daddr[c];
      req[c].cctrans = snp_busy[c] ? snp_valid[c] : r_own[c];
      req[c].ccwrite = snp_busy[c] & snp_valid[c] & snp_dirty[c];
      req[c].dstore  = snp_busy[c] ? snp_data[c] : r_store[c];
    end
  end

  // peer answers after 0..3 cycles as dirty or clean at random
  always @(negedge CLK) begin
    for (int c = 0; c < 2; c++) begin
      if (!nRST || !resp[c].ccwait) begin
        snp_busy[c]  = 1'b0;
        snp_valid[c] = 1'b0;
      end else if (!snp_busy[c]) begin
        snp_busy[c]  = 1'b1;
        snp_cnt[c]   = 2'($urandom_range(0, 3));
        snp_dirty[c] = 1'($urandom_range(0, 1));
        snp_data[c]  = $urandom;
        snp_valid[c] = (snp_cnt[c] == 2'd0);
      end else if (!snp_valid[c]) begin
        snp_cnt[c]   = snp_cnt[c] - 2'd1;
        snp_valid[c] = (snp_cnt[c] == 2'd0);
      end
    end
  end

  task automatic drop_request(input int c);
    r_iren[c] = 1'b0;
    r_dren[c] = 1'b0;
    r_dwen[c] = 1'b0;
    r_own[c]  = 1'b0;
  endtask

  // one core's cache side driven on falling edges
  task automatic run_core(input int c);
    int op;
    int gap;
    int cycles;
    bit done;
    for (int n = 0; n < TXNS && !abort; n++) begin
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0; // mostly back to back
      if (gap > 0) begin
        drop_request(c);
        repeat (gap) @(negedge CLK);
      end
      op = $urandom_range(0, 3); // fetch, shared read, ownership read, writeback
      r_iren[c]  = (op == 0);
      r_dren[c]  = (op == 1) || (op == 2);
      r_dwen[c]  = (op == 3);
      r_own[c]   = (op == 2);
      r_iaddr[c] = ADDR_W'($urandom_range(0, 15)); // low addresses for many conflicts
      r_daddr[c] = ADDR_W'($urandom_range(0, 15));
      r_store[c] = $urandom;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < TIMEOUT) begin
        @(posedge CLK);
        cycles++;
        done = (op == 0) ? !resp[c].iwait : !resp[c].dwait;
      end
      if (!done) begin
        $display("core %0d: request not completed within %0d cycles", c, TIMEOUT);
        timeouts++;
        abort = 1'b1;
      end
      @(negedge CLK);
    end
    drop_request(c);
  endtask

  initial begin
    void'($urandom(32'h2083));
    nRST     = 1'b0;
    abort    = 1'b0;
    timeouts = 0;
    for (int c = 0; c < 2; c++) begin
      drop_request(c);
      r_iaddr[c]   = '0;
      r_daddr[c]   = '0;
      r_store[c]   = '0;
      snp_busy[c]  = 1'b0;
      snp_valid[c] = 1'b0;
      snp_dirty[c] = 1'b0;
      snp_cnt[c]   = '0;
      snp_data[c]  = '0;
    end
    repeat (2) @(negedge CLK); // two rising edges in reset
    nRST = 1'b1;
    fork
      run_core(0);
      run_core(1);
    join
    repeat (4) @(posedge CLK); // trailing ram writeback settles
    asrt_errors = dut0.ctrl0.asrt0.fails;
    $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts, %0d completions",
             chk_errors, asrt_errors, timeouts, chk_done);
    if (chk_errors == 0 && asrt_errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

// owner bit stays while the owner keeps asking
module bus_arbiter (
  input  logic       CLK,
  input  logic       nRST,
  input  logic [1:0] want,     // per core, any request pending
  input  logic       grant_en, // controller sits in IDLE
  output logic       owner
);

  logic next_owner;

  always_comb begin
    next_owner = owner;
    if (grant_en) begin
      if (want[owner])
        next_owner = owner;      // current owner keeps the bus
      else if (want[~owner])
        next_owner = ~owner;     // hand over to the other core
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      owner <= 1'b0; // core 0 first out of reset
    end else begin
      owner <= next_owner;
    end
  end

endmodule

// File: logic/coherence_pkg.sv
package coherence_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // ram geometry and timing
  localparam int RAM_WORDS = 256;              // addresses wrap on low bits
  localparam int RAM_AW    = $clog2(RAM_WORDS); // index bits actually used
  localparam int RAM_LAT   = 2;                // busy cycles before access
  localparam int LAT_W     = $clog2(RAM_LAT + 1);

  // ram handshake status
  typedef enum logic [1:0] {
    FREE,   // no request
    BUSY,   // request held, latency running
    ACCESS  // load valid / write taken this cycle
  } ramstate_t;

  // controller states
  typedef enum logic [3:0] {
    IDLE,
    SNOOP,      // waiting on peer reply
    BUS_RD_C,   // shared read, peer supplies
    BUS_RD_M,   // shared read from ram
    BUS_RDX_C,  // ownership read, peer supplies
    BUS_RDX_M,  // ownership read from ram
    BUS_WB,     // snooped dirty word back to ram
    WB_REQ,     // eviction writeback
    IMEM_RD     // instruction fetch
  } mc_state_t;

  // one core's cache side into the controller
  typedef struct packed {
    logic              iren;
    logic              dren;
    logic              dwen;
    logic              cctrans;  // ownership on dren or reply valid when snooped
    logic              ccwrite;  // peer has the word modified
    logic [ADDR_W-1:0] iaddr;
    logic [ADDR_W-1:0] daddr;
    logic [DATA_W-1:0] dstore;
  } cache_req_t;

  // controller back to one core
  typedef struct packed {
    logic              iwait;
    logic              dwait;
    logic [DATA_W-1:0] iload;
    logic [DATA_W-1:0] dload;
    logic              ccwait;
    logic              ccinv;
    logic [ADDR_W-1:0] ccsnoopaddr;
  } cache_resp_t;

  // ram port
  typedef struct packed {
    logic              ren;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] store;
  } ram_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] load;
    ramstate_t         state;
  } ram_resp_t;

endpackage

// File: logic/coherent_memory_top.sv
`timescale 1ns/1ps

// two cache ports over controller + shared ram
module coherent_memory_top import coherence_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  req [2],
  output cache_resp_t resp [2]
);

  // controller <-> ram
  ram_req_t  ram_req;
  ram_resp_t ram_resp;

  memory_control ctrl0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .resp     (resp),
    .ram_req  (ram_req),
    .ram_resp (ram_resp)
  );

  ram_model ram0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_req  (ram_req),
    .ram_resp (ram_resp)
  );

endmodule

// File: logic/memory_control.sv
`timescale 1ns/1ps

// coherence + arbitration for two cores on one ram
module memory_control import coherence_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  req [2],
  output cache_resp_t resp [2],
  output ram_req_t    ram_req,
  input  ram_resp_t   ram_resp
);

  mc_state_t state, next_state;

  logic       owner;      // served core outside IDLE
  logic       rr_armed;   // owner has had at least one turn
  logic [1:0] raw_want;   // any request level per core
  logic [1:0] want;       // after round-robin masking
  logic       sel;        // pick made in IDLE
  logic       cur;        // core being served
  logic       peer;       // the snooped core

  cache_req_t  rq, pr;            // requester / peer inputs
  cache_resp_t rq_resp, pr_resp;  // requester / peer outputs

  // word and address taken from a dirty snoop reply
  logic [DATA_W-1:0] wb_data;
  logic [ADDR_W-1:0] wb_addr;

  logic ram_done;
  assign ram_done = (ram_resp.state == ACCESS);

  // request levels per core
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      raw_want[i] = req[i].iren | req[i].dren | req[i].dwen;
    end
  end

  // owner just had its turn so on a tie the other core goes first
  always_comb begin
    want = raw_want;
    if (rr_armed && (raw_want == 2'b11))
      want[owner] = 1'b0;
  end

  bus_arbiter arb0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .want     (want),
    .grant_en (state == IDLE),
    .owner    (owner)
  );

  // same choice the arbiter stores at the clock edge
  assign sel  = want[owner] ? owner : ~owner;
  assign cur  = (state == IDLE) ? sel : owner;
  assign peer = ~cur;

  assign rq = req[cur];
  assign pr = req[peer];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      rr_armed <= 1'b0;
    end else begin
      state <= next_state;
      if (state == IDLE && next_state != IDLE)
        rr_armed <= 1'b1; // first grant seen
    end
  end

  // peer reply kept for after the requester lets go
  always_ff @(posedge CLK) begin
    if (state == SNOOP && pr.cctrans) begin
      wb_data <= pr.dstore;
      wb_addr <= rq.daddr; // same as ccsnoopaddr
    end
  end

  always_comb begin : next_logic
    next_state = state;
    case (state)
      IDLE: begin
        if (rq.dren)
          next_state = SNOOP;      // every data read snoops first
        else if (rq.dwen)
          next_state = WB_REQ;
        else if (rq.iren)
          next_state = IMEM_RD;
      end
      SNOOP: begin
        // hold here until the peer answers
        if (pr.cctrans) begin
          if (pr.ccwrite)
            next_state = rq.cctrans ? BUS_RDX_C : BUS_RD_C;
          else
            next_state = rq.cctrans ? BUS_RDX_M : BUS_RD_M;
        end
      end
      BUS_RD_C:  next_state = BUS_WB;   // peer drops to S and the word is still owed to ram
      BUS_RDX_C: next_state = IDLE;     // peer goes to I and ram stays stale
      BUS_RD_M:  next_state = ram_done ? IDLE : state;
      BUS_RDX_M: next_state = ram_done ? IDLE : state;
      BUS_WB:    next_state = ram_done ? IDLE : state;
      WB_REQ:    next_state = ram_done ? IDLE : state;
      IMEM_RD:   next_state = ram_done ? IDLE : state;
      default:   next_state = IDLE;
    endcase
  end

  always_comb begin : out_logic
    // waits up unless completing
    rq_resp = '0;
    rq_resp.iwait = 1'b1;
    rq_resp.dwait = 1'b1;
    pr_resp = '0;
    pr_resp.iwait = 1'b1;
    pr_resp.dwait = 1'b1;

    ram_req = '0;

    case (state)
      SNOOP: begin
        pr_resp.ccwait      = 1'b1;
        pr_resp.ccsnoopaddr = rq.daddr;
        // invalidate peer on the way out of an ownership snoop
        pr_resp.ccinv       = pr.cctrans & rq.cctrans;
      end
      BUS_RD_C, BUS_RDX_C: begin
        rq_resp.dwait = 1'b0;    // cache to cache in one cycle
        rq_resp.dload = wb_data;
      end
      BUS_RD_M, BUS_RDX_M: begin
        ram_req.ren   = 1'b1;
        ram_req.addr  = rq.daddr;
        rq_resp.dwait = ~ram_done;
        rq_resp.dload = ram_resp.load;
      end
      BUS_WB: begin
        // requester already done so only ram traffic is left
        ram_req.wen   = 1'b1;
        ram_req.addr  = wb_addr;
        ram_req.store = wb_data;
      end
      WB_REQ: begin
        ram_req.wen   = 1'b1;
        ram_req.addr  = rq.daddr;
        ram_req.store = rq.dstore;
        rq_resp.dwait = ~ram_done;
      end
      IMEM_RD: begin
        ram_req.ren   = 1'b1;
        ram_req.addr  = rq.iaddr;
        rq_resp.iwait = ~ram_done;
        rq_resp.iload = ram_resp.load;
      end
      default: ; // nothing driven in IDLE
    endcase
  end

  // steer requester/peer views back to core slots
  assign resp[0] = cur ? pr_resp : rq_resp;
  assign resp[1] = cur ? rq_resp : pr_resp;

endmodule

// File: logic/ram_model.sv
`timescale 1ns/1ps

// word ram with fixed latency and busy/access status
module ram_model import coherence_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  ram_req_t  ram_req,
  output ram_resp_t ram_resp
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [LAT_W-1:0]  cnt;      // cycles into the current request
  logic [RAM_AW-1:0] idx;      // wrapped word index
  logic              active;
  logic              at_access;

  assign idx       = ram_req.addr[RAM_AW-1:0];
  assign active    = ram_req.ren | ram_req.wen;
  assign at_access = active && (cnt == LAT_W'(RAM_LAT));

  // latency counter restarts on drop or after access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (!active || at_access) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // contents start at zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (ram_req.wen && at_access) begin
      mem[idx] <= ram_req.store; // write lands at ACCESS
    end
  end

  always_comb begin
    ram_resp.load = mem[idx]; // only meaningful at ACCESS
    if (!active)
      ram_resp.state = FREE;
    else if (at_access)
      ram_resp.state = ACCESS;
    else
      ram_resp.state = BUSY;
  end

endmodule

// File: sim.f
logic/coherence_pkg.sv
logic/bus_arbiter.sv
logic/memory_control.sv
logic/ram_model.sv
logic/coherent_memory_top.sv
bench/memory_control_assertions.sv
bench/memory_control_checker.sv
bench/memory_control_tb.sv
